// ==== source/bayer_sel_pkg.sv ====
/*
 * Shared constants for the Bayer colour tagger.
 * Pattern codes name the colours of the first two pixels of a frame.
 * Mono detection uses the low 7 bits of the U3V pixel-format word only.
 */
`default_nettype none

package bayer_sel_pkg;

	// ----------------------------------------
	// Bayer pattern codes
	// ----------------------------------------
	// First row starts G then R
	parameter int PATTERN_GR = 0;
	// First row starts R then G
	parameter int PATTERN_RG = 1;
	// First row starts G then B
	parameter int PATTERN_GB = 2;
	// First row starts B then G
	parameter int PATTERN_BG = 3;

	// ----------------------------------------
	// Default widths
	// ----------------------------------------
	parameter int DEF_PIX_WIDTH   = 10;
	parameter int DEF_CHANNEL_NUM = 4;
	parameter int DEF_REG_WIDTH   = 32;

	// ----------------------------------------
	// U3V mono pixel formats
	// ----------------------------------------
	// Low bits that identify a mono code
	parameter int FMT_ID_WIDTH = 7;
	parameter int MONO_FMT_NUM = 10;

	// Mono1p, Mono2p, Mono4p, Mono8, Mono10,
	// Mono10p, Mono12, Mono12p, Mono14, Mono16
	parameter logic [FMT_ID_WIDTH-1:0] MONO_FMT_IDS [MONO_FMT_NUM] = '{
		7'h37, 7'h38, 7'h39, 7'h01, 7'h03,
		7'h46, 7'h05, 7'h47, 7'h25, 7'h07
	};

endpackage

`default_nettype wire

// ==== source/mono_format_decode.sv ====
/*
 * Mono detection from the U3V pixel-format register.
 * Only the low FMT_ID_WIDTH bits are compared, the bits above are ignored.
 * Result is registered, so a format change shows one cycle later.
 * The format is expected to change only between frames.
 */
`timescale 1ns/1ps
`default_nettype none

module mono_format_decode #(
	parameter int REG_WIDTH = bayer_sel_pkg::DEF_REG_WIDTH
) (
	input  wire logic                 clk,
	input  wire logic                 i_arst_n,
	input  wire logic [REG_WIDTH-1:0] iv_pixel_format,
	output logic                      o_mono_sel
);

	import bayer_sel_pkg::*;

	// Format word must at least hold the id field
	generate
		if (REG_WIDTH < FMT_ID_WIDTH) begin : g_bad_width
			$fatal(1, "REG_WIDTH %0d is narrower than the format id", REG_WIDTH);
		end
	endgenerate

	// ----------------------------------------
	// Table match
	// ----------------------------------------
	logic [FMT_ID_WIDTH-1:0] fmt_id;
	logic                    fmt_match;

	// Id field of the register
	assign fmt_id = iv_pixel_format[FMT_ID_WIDTH-1:0];

	// Any hit in the mono table
	always_comb begin
		fmt_match = 1'b0;
		for (int i = 0; i < MONO_FMT_NUM; i++) begin
			if (fmt_id == MONO_FMT_IDS[i]) begin
				fmt_match = 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Registered mono select
	// ----------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mono_sel <= 1'b0;
		end else begin
			o_mono_sel <= fmt_match;
		end
	end

endmodule

`default_nettype wire

// ==== source/video_sync_delay.sv ====
/*
 * One-cycle re-timing of frame-valid, line-valid and pixel data.
 * Also keeps the odd/even line parity for the Bayer row phase.
 * Parity toggles after each line end, and clears between frames
 * and while a mono format is selected.
 */
`timescale 1ns/1ps
`default_nettype none

module video_sync_delay #(
	parameter int DATA_WIDTH = bayer_sel_pkg::DEF_PIX_WIDTH * bayer_sel_pkg::DEF_CHANNEL_NUM
) (
	input  wire logic                  clk,
	input  wire logic                  i_arst_n,
	input  wire logic                  i_fval,
	input  wire logic                  i_lval,
	input  wire logic                  i_mono_sel,
	input  wire logic [DATA_WIDTH-1:0] iv_pix_data,
	output logic                       o_fval,
	output logic                       o_lval,
	output logic                       o_line_odd,
	output logic [DATA_WIDTH-1:0]      ov_pix_data
);

	logic lval_fall;

	// ----------------------------------------
	// Delay stage
	// ----------------------------------------
	// All outputs read low straight after reset
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_fval      <= 1'b0;
			o_lval      <= 1'b0;
			ov_pix_data <= '0;
		end else begin
			o_fval      <= i_fval;
			o_lval      <= i_lval;
			ov_pix_data <= iv_pix_data;
		end
	end

	// ----------------------------------------
	// Line parity
	// ----------------------------------------
	// End of line, seen against the delayed copy
	assign lval_fall = o_lval & ~i_lval;

	// Even line first in every frame
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_line_odd <= 1'b0;
		end else if (!i_fval || i_mono_sel) begin
			// Idle between frames and in mono mode
			o_line_odd <= 1'b0;
		end else if (lval_fall) begin
			o_line_odd <= ~o_line_odd;
		end
	end

endmodule

`default_nettype wire

// ==== source/cfa_flag_gen.sv ====
/*
 * Per-channel R, G and B flags for a Bayer colour-filter stream.
 * CHANNEL_NUM is 1 or even; pixel 0 of a word sits in channel 0.
 * Flags are registered and line up with the delayed line-valid.
 * Line parity comes from outside and must be settled before a line starts.
 * Flags are all zero outside a line and in mono mode.
 */
`timescale 1ns/1ps
`default_nettype none

module cfa_flag_gen #(
	parameter int BAYER_PATTERN = bayer_sel_pkg::PATTERN_GR,
	parameter int CHANNEL_NUM   = bayer_sel_pkg::DEF_CHANNEL_NUM
) (
	input  wire logic                   clk,
	input  wire logic                   i_arst_n,
	input  wire logic                   i_lval,
	input  wire logic                   i_mono_sel,
	input  wire logic                   i_line_odd,
	output logic      [CHANNEL_NUM-1:0] ov_r_flag,
	output logic      [CHANNEL_NUM-1:0] ov_g_flag,
	output logic      [CHANNEL_NUM-1:0] ov_b_flag
);

	import bayer_sel_pkg::*;

	// ----------------------------------------
	// Elaboration checks
	// ----------------------------------------
	generate
		if (CHANNEL_NUM < 1 || (CHANNEL_NUM > 1 && CHANNEL_NUM % 2 != 0)) begin : g_bad_ch
			$fatal(1, "CHANNEL_NUM %0d must be 1 or even", CHANNEL_NUM);
		end
		if (BAYER_PATTERN < PATTERN_GR || BAYER_PATTERN > PATTERN_BG) begin : g_bad_pat
			$fatal(1, "Unsupported BAYER_PATTERN code %0d", BAYER_PATTERN);
		end
	endgenerate

	// ----------------------------------------
	// Pattern layout
	// ----------------------------------------
	// Green at row 0, column 0 for GR and GB
	localparam logic GREEN_FIRST = (BAYER_PATTERN == PATTERN_GR) ||
		(BAYER_PATTERN == PATTERN_GB);
	// Row that carries red, the other one carries blue
	localparam logic RED_ROW = !((BAYER_PATTERN == PATTERN_GR) ||
		(BAYER_PATTERN == PATTERN_RG));

	// Colour at a (row, column) parity, packed as {r, g, b}
	function automatic logic [2:0] cfa_colour(input logic row, input logic col);
		logic is_green;
		// Green sits on the diagonal through the first green pixel
		is_green = ((row ^ col) == !GREEN_FIRST);
		cfa_colour = {!is_green && (row == RED_ROW), is_green, !is_green && (row != RED_ROW)};
	endfunction

	// ----------------------------------------
	// Column parity per lane
	// ----------------------------------------
	logic [CHANNEL_NUM-1:0] lane_col;
	logic [CHANNEL_NUM-1:0] r_nxt;
	logic [CHANNEL_NUM-1:0] g_nxt;
	logic [CHANNEL_NUM-1:0] b_nxt;

	generate
		if (CHANNEL_NUM == 1) begin : g_single
			// One pixel per clock, column walks with time
			logic pix_odd;

			always_ff @(posedge clk or negedge i_arst_n) begin
				if (!i_arst_n) begin
					pix_odd <= 1'b0;
				end else if (!i_lval || i_mono_sel) begin
					// Restart at each line
					pix_odd <= 1'b0;
				end else begin
					pix_odd <= ~pix_odd;
				end
			end

			assign lane_col[0] = pix_odd;
		end else begin : g_multi
			// Even word width, so each lane keeps a fixed column
			for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_lane
				assign lane_col[c] = 1'(c % 2);
			end
		end
	endgenerate

	// ----------------------------------------
	// Colour lookup
	// ----------------------------------------
	generate
		for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_colour
			assign {r_nxt[c], g_nxt[c], b_nxt[c]} = cfa_colour(i_line_odd, lane_col[c]);
		end
	endgenerate

	// ----------------------------------------
	// Flag registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ov_r_flag <= '0;
			ov_g_flag <= '0;
			ov_b_flag <= '0;
		end else if (!i_lval || i_mono_sel) begin
			// No statistics outside a line or in mono
			ov_r_flag <= '0;
			ov_g_flag <= '0;
			ov_b_flag <= '0;
		end else begin
			ov_r_flag <= r_nxt;
			ov_g_flag <= g_nxt;
			ov_b_flag <= b_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== source/bayer_sel_top.sv ====
/*
 * Bayer colour tagger, top level.
 * Free-running stream, no back-pressure: one word accepted every cycle.
 * All outputs are the input of one cycle earlier plus colour flags.
 * CHANNEL_NUM must be 1 or even.
 */
`timescale 1ns/1ps
`default_nettype none

module bayer_sel_top #(
	parameter int BAYER_PATTERN = bayer_sel_pkg::PATTERN_GR,
	parameter int PIX_WIDTH     = bayer_sel_pkg::DEF_PIX_WIDTH,
	parameter int CHANNEL_NUM   = bayer_sel_pkg::DEF_CHANNEL_NUM,
	parameter int REG_WIDTH     = bayer_sel_pkg::DEF_REG_WIDTH
) (
	input  wire logic                             clk,
	input  wire logic                             i_arst_n,
	input  wire logic                             i_fval,
	input  wire logic                             i_lval,
	input  wire logic [PIX_WIDTH*CHANNEL_NUM-1:0] iv_pix_data,
	input  wire logic [REG_WIDTH-1:0]             iv_pixel_format,
	output logic                                  o_fval,
	output logic                                  o_lval,
	output logic      [PIX_WIDTH*CHANNEL_NUM-1:0] ov_pix_data,
	output logic                                  o_mono_sel,
	output logic      [CHANNEL_NUM-1:0]           ov_r_flag,
	output logic      [CHANNEL_NUM-1:0]           ov_g_flag,
	output logic      [CHANNEL_NUM-1:0]           ov_b_flag
);

	// Shared between the blocks
	logic mono_sel;
	logic line_odd;

	assign o_mono_sel = mono_sel;

	// ----------------------------------------
	// Format decode
	// ----------------------------------------
	mono_format_decode #(
		.REG_WIDTH (REG_WIDTH)
	) u_mono_format_decode (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.iv_pixel_format (iv_pixel_format),
		.o_mono_sel      (mono_sel)
	);

	// ----------------------------------------
	// Stream delay and line parity
	// ----------------------------------------
	video_sync_delay #(
		.DATA_WIDTH (PIX_WIDTH * CHANNEL_NUM)
	) u_video_sync_delay (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_fval      (i_fval),
		.i_lval      (i_lval),
		.i_mono_sel  (mono_sel),
		.iv_pix_data (iv_pix_data),
		.o_fval      (o_fval),
		.o_lval      (o_lval),
		.o_line_odd  (line_odd),
		.ov_pix_data (ov_pix_data)
	);

	// Flags take the raw line-valid, so they land with o_lval
	cfa_flag_gen #(
		.BAYER_PATTERN (BAYER_PATTERN),
		.CHANNEL_NUM   (CHANNEL_NUM)
	) u_cfa_flag_gen (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_lval     (i_lval),
		.i_mono_sel (mono_sel),
		.i_line_odd (line_odd),
		.ov_r_flag  (ov_r_flag),
		.ov_g_flag  (ov_g_flag),
		.ov_b_flag  (ov_b_flag)
	);

endmodule

`default_nettype wire

// ==== test/bayer_sel_chk.sv ====
/*
 * Concurrent checks for the Bayer colour tagger, bound into the top level.
 * Reset values, one-cycle re-timing and one colour per channel.
 */
`timescale 1ns/1ps
`default_nettype none

module bayer_sel_chk #(
	parameter int CHANNEL_NUM = bayer_sel_pkg::DEF_CHANNEL_NUM,
	parameter int DATA_WIDTH  = bayer_sel_pkg::DEF_PIX_WIDTH * bayer_sel_pkg::DEF_CHANNEL_NUM
) (
	input wire logic                   clk,
	input wire logic                   i_arst_n,
	input wire logic                   i_fval,
	input wire logic                   i_lval,
	input wire logic [DATA_WIDTH-1:0]  iv_pix_data,
	input wire logic                   o_fval,
	input wire logic                   o_lval,
	input wire logic [DATA_WIDTH-1:0]  ov_pix_data,
	input wire logic                   o_mono_sel,
	input wire logic [CHANNEL_NUM-1:0] ov_r_flag,
	input wire logic [CHANNEL_NUM-1:0] ov_g_flag,
	input wire logic [CHANNEL_NUM-1:0] ov_b_flag
);

	logic [CHANNEL_NUM-1:0] any_flag;

	assign any_flag = ov_r_flag | ov_g_flag | ov_b_flag;

	// Low in reset and in the first cycle after it
	a_reset_low: assert property (@(posedge clk)
		(!i_arst_n || $rose(i_arst_n)) |-> !o_fval && !o_lval && !o_mono_sel
			&& ov_pix_data == '0 && any_flag == '0)
		else $error("Outputs not low around reset");

	a_retime: assert property (@(posedge clk)
		i_arst_n && $past(i_arst_n) |-> o_fval == $past(i_fval)
			&& o_lval == $past(i_lval) && ov_pix_data == $past(iv_pix_data))
		else $error("Output stream is not the input delayed by one cycle");

	a_idle_flags: assert property (@(posedge clk) disable iff (!i_arst_n)
		!o_lval |-> any_flag == '0)
		else $error("Colour flags set outside a line");

	// One colour per lane inside a Bayer line
	generate
		for (genvar c = 0; c < CHANNEL_NUM; c++) begin : g_lane
			a_one_colour: assert property (@(posedge clk) disable iff (!i_arst_n)
				o_lval && !o_mono_sel |-> $onehot({ov_r_flag[c], ov_g_flag[c], ov_b_flag[c]}))
				else $error("Channel %0d does not carry exactly one colour", c);
		end
	endgenerate

endmodule

`default_nettype wire

// ==== test/tb_bayer_sel.sv ====
/*
 * Testbench for the Bayer colour tagger.
 * Random frames from a fixed-seed Galois LFSR drive the DUT.
 * Flags and mono select are checked against a colour model of the CFA.
 * Reset, re-timing and flag exclusivity are checked in the bound checker.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_bayer_sel #(
	parameter int BAYER_PATTERN = bayer_sel_pkg::PATTERN_GR,
	parameter int CHANNEL_NUM   = bayer_sel_pkg::DEF_CHANNEL_NUM
);

	import bayer_sel_pkg::*;

	localparam int DW           = DEF_PIX_WIDTH * CHANNEL_NUM;
	localparam int LINES        = 5;
	localparam int BAYER_FRAMES = 6;
	// Longest frame is a lead cycle, 19-word lines with 4-cycle gaps and an idle tail
	localparam int FRAME_MAX    = 1 + LINES * 23 + 3;
	localparam int PLAN_CYCLES  = 3 + (MONO_FMT_NUM + BAYER_FRAMES) * FRAME_MAX + 21;
	localparam int CYCLE_LIMIT  = 2 * PLAN_CYCLES + 100;

	logic clk = 1'b0;
	logic i_arst_n, i_fval, i_lval, o_fval, o_lval, o_mono_sel;
	logic [DW-1:0] iv_pix_data, ov_pix_data;
	logic [DEF_REG_WIDTH-1:0] iv_pixel_format, fmt;
	logic [CHANNEL_NUM-1:0] ov_r_flag, ov_g_flag, ov_b_flag;
	logic [CHANNEL_NUM-1:0] exp_r = '0, exp_g = '0, exp_b = '0;
	logic exp_mono = 1'b0;
	logic [31:0] lfsr = 32'h4503230d;
	int cycle_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;

	bayer_sel_top #(
		.BAYER_PATTERN (BAYER_PATTERN),
		.PIX_WIDTH     (DEF_PIX_WIDTH),
		.CHANNEL_NUM   (CHANNEL_NUM),
		.REG_WIDTH     (DEF_REG_WIDTH)
	) DUT (.*);

	bind bayer_sel_top bayer_sel_chk #(
		.CHANNEL_NUM (CHANNEL_NUM),
		.DATA_WIDTH  (PIX_WIDTH * CHANNEL_NUM)
	) u_chk (.*);

	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// Random source and reference model
	// ----------------------------------------
	function automatic logic rand_bit();
		// Right-shift Galois step for each bit taken
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic int rand_num(input int bits);
		int value;
		value = 0;
		for (int i = 0; i < bits; i++) begin
			value = (value << 1) | int'(rand_bit());
		end
		return value;
	endfunction

	function automatic logic is_mono(input logic [DEF_REG_WIDTH-1:0] fmt_word);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < MONO_FMT_NUM; i++) begin
			hit = hit || (fmt_word[FMT_ID_WIDTH-1:0] == MONO_FMT_IDS[i]);
		end
		return hit;
	endfunction

	// Colour code at row and column parity is 0 red, 1 green or 2 blue
	function automatic int bayer_colour(input int row, input int col);
		logic [7:0] cfa;
		// Two bits per site in the order {r1c1, r1c0, r0c1, r0c0}
		case (BAYER_PATTERN)
			PATTERN_GR: cfa = {2'd1, 2'd2, 2'd0, 2'd1};
			PATTERN_RG: cfa = {2'd2, 2'd1, 2'd1, 2'd0};
			PATTERN_GB: cfa = {2'd1, 2'd0, 2'd2, 2'd1};
			default:    cfa = {2'd0, 2'd1, 2'd1, 2'd2};
		endcase
		cfa = cfa >> ((row * 2 + col) * 2);
		return int'(cfa[1:0]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_cnt++;
		assert (actual === expected) else begin
			$display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			err_cnt++;
		end
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	// Checks the previous word's response and drives the next word
	task automatic drive_cycle(input logic fval, input logic lval, input int row, input int pix);
		int colour;
		@(posedge clk);
		#10;
		check_value("o_mono_sel", 32'(exp_mono), 32'(o_mono_sel));
		check_value("ov_r_flag", 32'(exp_r), 32'(ov_r_flag));
		check_value("ov_g_flag", 32'(exp_g), 32'(ov_g_flag));
		check_value("ov_b_flag", 32'(exp_b), 32'(ov_b_flag));
		i_fval = fval;
		i_lval = lval;
		iv_pixel_format = fmt;
		for (int b = 0; b < DW; b++) begin
			iv_pix_data[b] = rand_bit();
		end
		exp_mono = is_mono(fmt);
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			// Column is the lane in wide words and the pixel count in narrow ones
			colour = bayer_colour(row % 2, (CHANNEL_NUM == 1) ? pix % 2 : c % 2);
			exp_r[c] = lval && !exp_mono && colour == 0;
			exp_g[c] = lval && !exp_mono && colour == 1;
			exp_b[c] = lval && !exp_mono && colour == 2;
		end
	endtask

	task automatic run_frame();
		int len;
		int gap;
		drive_cycle(1'b1, 1'b0, 0, 0);
		for (int ln = 0; ln < LINES; ln++) begin
			len = 4 + rand_num(4);
			gap = 1 + rand_num(2);
			for (int p = 0; p < len; p++) begin
				drive_cycle(1'b1, 1'b1, ln, p);
			end
			repeat (gap) drive_cycle(1'b1, 1'b0, ln, 0);
		end
		// Frame-valid low clears the line parity
		repeat (3) drive_cycle(1'b0, 1'b0, 0, 0);
	endtask

	initial begin
		logic [DEF_REG_WIDTH-1:0] code;
		int prev_err;
		i_arst_n = 1'b0;
		// Live stream and a mono format while reset holds the outputs low
		i_fval = 1'b1;
		i_lval = 1'b1;
		iv_pix_data = '1;
		iv_pixel_format = '0;
		iv_pixel_format[FMT_ID_WIDTH-1:0] = MONO_FMT_IDS[0];
		fmt = '0;
		repeat (3) @(posedge clk);
		#10;
		i_arst_n = 1'b1;
		i_fval = 1'b0;
		i_lval = 1'b0;
		iv_pix_data = '0;
		iv_pixel_format = '0;
		$display("test reset: released after 3 cycles");

		prev_err = err_cnt;
		// One frame for every mono id under random upper bits
		for (int i = 0; i < MONO_FMT_NUM; i++) begin
			fmt = {25'(rand_num(25)), MONO_FMT_IDS[i]};
			run_frame();
		end
		// Random codes pushed off the mono table
		for (int i = 0; i < 10; i++) begin
			code = {16'(rand_num(16)), 16'(rand_num(16))};
			while (is_mono(code)) begin
				code[6:0] = code[6:0] + 7'd1;
			end
			fmt = code;
			drive_cycle(1'b0, 1'b0, 0, 0);
			drive_cycle(1'b0, 1'b0, 0, 0);
		end
		$display("test mono_decode: %0d errors", err_cnt - prev_err);

		prev_err = err_cnt;
		// BayerGR8 code lies outside the mono table
		fmt = 32'h0108_0008;
		repeat (BAYER_FRAMES) run_frame();
		drive_cycle(1'b0, 1'b0, 0, 0);
		$display("test bayer_pattern: %0d errors", err_cnt - prev_err);

		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/bayer_sel_pkg.sv
source/mono_format_decode.sv
source/video_sync_delay.sv
source/cfa_flag_gen.sv
source/bayer_sel_top.sv
test/bayer_sel_chk.sv
test/tb_bayer_sel.sv

// ==== Makefile ====
# Verilator build and run of the Bayer colour tagger testbench
VERILATOR   := verilator
TOP         := tb_bayer_sel
FILELIST    := filelist.f
BUILD_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS  := --lint-only --timing -Wall
FAIL_MSG    := TEST RESULT: FAIL
PASS_MSG    := TEST RESULT: PASS
CFG_gr4     := -GBAYER_PATTERN=0 -GCHANNEL_NUM=4
CFG_rg1     := -GBAYER_PATTERN=1 -GCHANNEL_NUM=1
CONFIGS     := gr4 rg1

.PHONY: all lint clean $(CONFIGS)

all: $(CONFIGS)
	@for cfg in $(CONFIGS); do \
		if grep -q "$(FAIL_MSG)" sim_$$cfg.log || ! grep -q "$(PASS_MSG)" sim_$$cfg.log; then \
			echo "Configuration $$cfg failed, see sim_$$cfg.log"; exit 1; \
		fi; \
	done

$(CONFIGS):
	$(VERILATOR) $(BUILD_FLAGS) $(CFG_$@) --top-module $(TOP) --Mdir obj_$@ -f $(FILELIST)
	-./obj_$@/V$(TOP) > sim_$@.log 2>&1

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(CONFIGS:%=obj_%) $(CONFIGS:%=sim_%.log)
